/* verif/book_testdata.txt */
// Columns: command word, expected top key, top volume, count, notify flag
// Command word is cmd[31:30] key[29:14] volume[13:0]
00000000 0000 0000 00 0 // CLEAR on empty table
41400051 0500 0051 01 1 // ADD 0500
40C00033 0500 0051 02 0 // ADD 0300 below top
41C00077 0700 0077 03 1 // ADD 0700 new top
40400011 0700 0077 04 0 // ADD 0100
41800066 0700 0077 05 0 // ADD 0600
40800022 0700 0077 06 0 // ADD 0200
42400099 0900 0099 07 1 // ADD 0900 new top
41000044 0900 0099 08 0 // ADD 0400 fills the table
42000088 0900 0099 08 0 // ADD 0800 on full, 0100 lost
60003FFF 8000 3FFF 08 1 // ADD 8000 on full, 0200 lost
40200008 8000 3FFF 08 0 // ADD 0080 lower than all, dropped
E0001234 8000 1234 08 1 // REPLACE top volume
C1800666 8000 1234 08 0 // REPLACE 0600 below top
C2800AAA 8000 1234 08 0 // REPLACE missing key
80400000 8000 1234 08 0 // DELETE missing key 0100
A0000000 0900 0099 07 1 // DELETE top 8000
81C00000 0900 0099 06 0 // DELETE 0700 in the middle
82400000 0800 0088 05 1 // DELETE top 0900
82000000 0600 0666 04 1 // DELETE top 0800, replaced volume shows
81800000 0500 0051 03 1 // DELETE top 0600
43000CCC 0C00 0CCC 04 1 // ADD 0C00 new top
80C00000 0C00 0CCC 03 0 // DELETE lowest 0300
C3000CCC 0C00 0CCC 03 0 // REPLACE top with same volume
00000000 0000 0000 00 1 // CLEAR non-empty table
00000000 0000 0000 00 0 // CLEAR on empty table
81400000 0000 0000 00 0 // DELETE on empty table
40800002 0200 0002 01 1 // ADD 0200
80800000 0000 0000 00 1 // DELETE last entry
41001000 0400 1000 01 1 // ADD 0400

/* vlog.f */
logic/book_pkg.sv
logic/book_cmd_port.sv
logic/book_level_update.sv
logic/book_level_table.sv
logic/book_top_notify.sv
logic/book_top.sv
verif/tb_clock_gen.sv
verif/tb_book_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the order book testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_book_top -o sim_book

./obj_dir/sim_book > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  exit 1
fi
exit 0

/* verif/tb_book_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Order book testbench
// Loads command words and expected results, drives the
// Wishbone slave, checks top-of-book, count and notify,
// watchdog on total run time
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_book_top;

  timeunit 1ns;
  timeprecision 100ps;

  import book_pkg::*;

  localparam int DEPTH           = 8;
  localparam int CLK_PERIOD_NS   = 8;
  localparam int MAX_LINES       = 64;
  localparam int WORDS_PER_LINE  = 5;
  localparam int CYCLES_PER_LINE = 20;
  localparam int ACK_LIMIT       = 8;

  logic     clk;
  logic     rst_n;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  logic     wb_adr;
  wb_data_t wb_dat_w;
  wb_data_t wb_dat_r;
  logic     wb_ack;
  logic     notify_vld;
  key_t     notify_key;
  volume_t  notify_volume;

  // Five words per transaction: cmd, key, volume, count, notify flag
  logic [31:0] vectors [MAX_LINES*WORDS_PER_LINE];
  int          num_lines;
  logic        loaded;
  int          line_idx;
  int          mismatch_cnt;
  int          other_cnt;
  int          notify_total;
  key_t        last_notify_key;
  volume_t     last_notify_volume;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (3)
  ) u_clock_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  book_top #(
    .BOOK_DEPTH (DEPTH)
  ) u_dut (
    .i_clk           (clk),
    .i_rst_n         (rst_n),
    .i_wb_cyc        (wb_cyc),
    .i_wb_stb        (wb_stb),
    .i_wb_we         (wb_we),
    .i_wb_adr        (wb_adr),
    .i_wb_dat        (wb_dat_w),
    .o_wb_dat        (wb_dat_r),
    .o_wb_ack        (wb_ack),
    .o_notify_vld    (notify_vld),
    .o_notify_key    (notify_key),
    .o_notify_volume (notify_volume)
  );

  // 32-bit xorshift step for the idle gap
  function automatic logic [31:0] xorshift_next(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Count notify pulses and keep the last payload
  always @(posedge clk) begin
    if (!rst_n) begin
      notify_total <= 0;
    end else if (notify_vld) begin
      notify_total       <= notify_total + 1;
      last_notify_key    <= notify_key;
      last_notify_volume <= notify_volume;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      mismatch_cnt++;
      $display("MISMATCH %s: got 0x%0h expected 0x%0h (line %0d)", name, got, exp, line_idx);
    end
  endtask

  // One classic cycle, held until ack, then one idle edge to catch a stuck ack
  task automatic bus_transfer(input logic we, input logic adr, input wb_data_t wdata,
                              output wb_data_t rdata);
    int   waited;
    logic got_ack;
    waited  = 0;
    got_ack = 1'b0;
    rdata   = '0;
    @(posedge clk);
    assert (!wb_ack) else begin
      other_cnt++;
      $display("ERROR: ack seen while no transfer was pending (line %0d)", line_idx);
    end
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    while (!got_ack && waited < ACK_LIMIT) begin
      @(posedge clk);
      waited++;
      if (wb_ack) begin
        got_ack = 1'b1;
        rdata   = wb_dat_r;
      end
    end
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    assert (got_ack) else begin
      other_cnt++;
      $display("ERROR: no ack within %0d cycles for %s at adr %0d (line %0d)",
               ACK_LIMIT, we ? "write" : "read", adr, line_idx);
    end
    @(posedge clk);
    assert (!wb_ack) else begin
      other_cnt++;
      $display("ERROR: ack stayed high for more than one cycle (line %0d)", line_idx);
    end
  endtask

  // Load vectors, end of data is the first slot whose flag is not 0 or 1
  initial begin
    loaded    = 1'b0;
    num_lines = 0;
    for (int a = 0; a < MAX_LINES * WORDS_PER_LINE; a++) begin
      vectors[a] = 32'hFFFF0000 ^ 32'(a);
    end
    $readmemh("verif/book_testdata.txt", vectors);
    while (num_lines < MAX_LINES && vectors[num_lines*WORDS_PER_LINE+4] <= 32'd1) begin
      num_lines++;
    end
    loaded = 1'b1;
  end

  // Main sequence
  initial begin
    wb_data_t    rd_top;
    wb_data_t    rd_cnt;
    wb_data_t    unused_rd;
    logic [31:0] rng_state;
    logic [31:0] cmd_word;
    key_t        exp_key;
    volume_t     exp_volume;
    level_t      exp_count;
    logic        exp_notify;
    int          base;
    int          idle_cycles;
    int          notify_before;
    int          notify_seen;

    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = 1'b0;
    wb_dat_w     = '0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    line_idx     = 0;
    rng_state    = 32'h5a59;

    wait (loaded);
    if (num_lines == 0) begin
      other_cnt++;
      $display("ERROR: no transactions found in the data file");
    end
    // Reset release seen on a clock edge
    while (rst_n !== 1'b1) @(posedge clk);
    @(posedge clk);

    for (line_idx = 0; line_idx < num_lines; line_idx++) begin
      base       = line_idx * WORDS_PER_LINE;
      cmd_word   = vectors[base];
      exp_key    = key_t'(vectors[base+1]);
      exp_volume = volume_t'(vectors[base+2]);
      exp_count  = level_t'(vectors[base+3]);
      exp_notify = vectors[base+4][0];

      notify_before = notify_total;
      bus_transfer(1'b1, 1'b0, cmd_word, unused_rd);

      // Random gap of 1 to 4 idle cycles before reading back
      rng_state   = xorshift_next(rng_state);
      idle_cycles = int'(rng_state % 32'd4) + 1;
      repeat (idle_cycles) @(posedge clk);

      bus_transfer(1'b0, 1'b0, '0, rd_top);
      bus_transfer(1'b0, 1'b1, '0, rd_cnt);

      check_value("o_wb_dat top key", 32'(rd_top[KEY_LSB +: KEY_BITS]), 32'(exp_key));
      check_value("o_wb_dat top volume", 32'(rd_top[VOLUME_LSB +: VOLUME_BITS]),
                  32'(exp_volume));
      check_value("o_wb_dat top spare bits", 32'(rd_top[31:30]), 32'd0);
      check_value("o_wb_dat count", rd_cnt, 32'(exp_count));

      // Exactly one pulse when the top moved, none otherwise
      notify_seen = notify_total - notify_before;
      check_value("o_notify_vld pulses", 32'(notify_seen), exp_notify ? 32'd1 : 32'd0);
      if (exp_notify && notify_seen == 1) begin
        check_value("o_notify_key", 32'(last_notify_key), 32'(exp_key));
        check_value("o_notify_volume", 32'(last_notify_volume), 32'(exp_volume));
      end
    end

    $display("Lines run %0d, mismatches %0d, other errors %0d",
             num_lines, mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog, limit grows with the number of transactions
  initial begin
    int limit_lines;
    wait (loaded);
    limit_lines = (num_lines > 0) ? num_lines : 1;
    #(limit_lines * CYCLES_PER_LINE * CLK_PERIOD_NS);
    $display("ERROR: run did not finish within %0d cycles (line %0d)",
             limit_lines * CYCLES_PER_LINE, line_idx);
    $display("Lines run %0d, mismatches %0d, other errors %0d",
             line_idx, mismatch_cnt, other_cnt + 1);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* verif/tb_clock_gen.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source
// Free running clock, active low reset held for a few
// rising edges and released synchronously
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic o_clk,
  output logic o_rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  // Half period toggle
  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // Reset low from time zero, released after the edges
  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

/* logic/book_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Order book top level
// Wishbone command port, level table and notifier
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module book_top #(
  parameter int BOOK_DEPTH = book_pkg::BOOK_DEPTH_DEFAULT
) (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_wb_cyc,
  input  logic               i_wb_stb,
  input  logic               i_wb_we,
  input  logic               i_wb_adr,
  input  book_pkg::wb_data_t i_wb_dat,
  output book_pkg::wb_data_t o_wb_dat,
  output logic               o_wb_ack,
  output logic               o_notify_vld,
  output book_pkg::key_t     o_notify_key,
  output book_pkg::volume_t  o_notify_volume
);

  import book_pkg::*;

  // Port to table command
  logic    cmd_vld;
  cmd_t    cmd;
  key_t    cmd_key;
  volume_t cmd_volume;

  // Table top entry and count
  key_t    top_key;
  volume_t top_volume;
  logic    top_vld;
  level_t  count;

  book_cmd_port u_cmd_port (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_wb_cyc     (i_wb_cyc),
    .i_wb_stb     (i_wb_stb),
    .i_wb_we      (i_wb_we),
    .i_wb_adr     (i_wb_adr),
    .i_wb_dat     (i_wb_dat),
    .o_wb_dat     (o_wb_dat),
    .o_wb_ack     (o_wb_ack),
    .o_cmd_vld    (cmd_vld),
    .o_cmd        (cmd),
    .o_cmd_key    (cmd_key),
    .o_cmd_volume (cmd_volume),
    .i_top_key    (top_key),
    .i_top_volume (top_volume),
    .i_top_vld    (top_vld),
    .i_count      (count)
  );

  book_level_table #(
    .BOOK_DEPTH (BOOK_DEPTH)
  ) u_level_table (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_cmd_vld    (cmd_vld),
    .i_cmd        (cmd),
    .i_cmd_key    (cmd_key),
    .i_cmd_volume (cmd_volume),
    .o_top_key    (top_key),
    .o_top_volume (top_volume),
    .o_top_vld    (top_vld),
    .o_count      (count)
  );

  book_top_notify #(
    .BOOK_DEPTH (BOOK_DEPTH)
  ) u_top_notify (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_top_key       (top_key),
    .i_top_volume    (top_volume),
    .i_top_vld       (top_vld),
    .o_notify_vld    (o_notify_vld),
    .o_notify_key    (o_notify_key),
    .o_notify_volume (o_notify_volume)
  );

endmodule

/* logic/book_top_notify.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top-of-book notifier
// Keeps the last reported top, pulses notify with the
// new top whenever the table top changes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module book_top_notify #(
  parameter int BOOK_DEPTH = book_pkg::BOOK_DEPTH_DEFAULT
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  book_pkg::key_t    i_top_key,
  input  book_pkg::volume_t i_top_volume,
  input  logic              i_top_vld,
  output logic              o_notify_vld,
  output book_pkg::key_t    o_notify_key,
  output book_pkg::volume_t o_notify_volume
);

  import book_pkg::*;

  logic    last_vld;
  key_t    last_key;
  volume_t last_volume;
  key_t    top_key;
  volume_t top_volume;
  logic    top_changed;

  // Empty top reads as zero so stale entries never compare
  assign top_key     = i_top_vld ? i_top_key : '0;
  assign top_volume  = i_top_vld ? i_top_volume : '0;
  assign top_changed = (i_top_vld != last_vld) || (top_key != last_key) ||
                       (top_volume != last_volume);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      last_vld     <= 1'b0;
      last_key     <= '0;
      last_volume  <= '0;
      o_notify_vld <= 1'b0;
    end else begin
      o_notify_vld <= top_changed;
      last_vld     <= i_top_vld;
      last_key     <= top_key;
      last_volume  <= top_volume;
    end
  end

  // Notify payload, meaningful only with the pulse
  always_ff @(posedge i_clk) begin
    o_notify_key    <= top_key;
    o_notify_volume <= top_volume;
  end

endmodule

/* logic/book_level_table.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Price level table registers
// Valid vector, keys, volumes and count, loaded from
// the update logic every cycle, top entry exposed
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module book_level_table #(
  parameter int BOOK_DEPTH = book_pkg::BOOK_DEPTH_DEFAULT
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_cmd_vld,
  input  book_pkg::cmd_t    i_cmd,
  input  book_pkg::key_t    i_cmd_key,
  input  book_pkg::volume_t i_cmd_volume,
  output book_pkg::key_t    o_top_key,
  output book_pkg::volume_t o_top_volume,
  output logic              o_top_vld,
  output book_pkg::level_t  o_count
);

  import book_pkg::*;

  // Current state
  logic [BOOK_DEPTH-1:0]    lvl_vld;
  key_t [BOOK_DEPTH-1:0]    lvl_keys;
  volume_t [BOOK_DEPTH-1:0] lvl_volumes;
  level_t                   lvl_count;

  // Next state from the update logic
  logic [BOOK_DEPTH-1:0]    nxt_vld;
  key_t [BOOK_DEPTH-1:0]    nxt_keys;
  volume_t [BOOK_DEPTH-1:0] nxt_volumes;
  level_t                   nxt_count;

  book_level_update #(
    .BOOK_DEPTH (BOOK_DEPTH)
  ) u_update (
    .i_cmd_vld     (i_cmd_vld),
    .i_cmd         (i_cmd),
    .i_cmd_key     (i_cmd_key),
    .i_cmd_volume  (i_cmd_volume),
    .i_cur_vld     (lvl_vld),
    .i_cur_keys    (lvl_keys),
    .i_cur_volumes (lvl_volumes),
    .i_cur_count   (lvl_count),
    .o_nxt_vld     (nxt_vld),
    .o_nxt_keys    (nxt_keys),
    .o_nxt_volumes (nxt_volumes),
    .o_nxt_count   (nxt_count)
  );

  // Empty table after reset
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      lvl_vld   <= '0;
      lvl_count <= '0;
    end else begin
      lvl_vld   <= nxt_vld;
      lvl_count <= nxt_count;
    end
  end

  always_ff @(posedge i_clk) begin
    lvl_keys    <= nxt_keys;
    lvl_volumes <= nxt_volumes;
  end

  // Highest price sits at the top index
  assign o_top_key    = lvl_keys[BOOK_DEPTH-1];
  assign o_top_volume = lvl_volumes[BOOK_DEPTH-1];
  assign o_top_vld    = lvl_vld[BOOK_DEPTH-1];
  assign o_count      = lvl_count;

endmodule

/* logic/book_level_update.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational next state of the sorted level table
// Key match, insertion point, shift masks, per-entry
// select and next level count
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module book_level_update #(
  parameter int BOOK_DEPTH = book_pkg::BOOK_DEPTH_DEFAULT
) (
  input  logic                                 i_cmd_vld,
  input  book_pkg::cmd_t                       i_cmd,
  input  book_pkg::key_t                       i_cmd_key,
  input  book_pkg::volume_t                    i_cmd_volume,
  input  logic [BOOK_DEPTH-1:0]                i_cur_vld,
  input  book_pkg::key_t [BOOK_DEPTH-1:0]      i_cur_keys,
  input  book_pkg::volume_t [BOOK_DEPTH-1:0]   i_cur_volumes,
  input  book_pkg::level_t                     i_cur_count,
  output logic [BOOK_DEPTH-1:0]                o_nxt_vld,
  output book_pkg::key_t [BOOK_DEPTH-1:0]      o_nxt_keys,
  output book_pkg::volume_t [BOOK_DEPTH-1:0]   o_nxt_volumes,
  output book_pkg::level_t                     o_nxt_count
);

  import book_pkg::*;

  localparam level_t DEPTH_LVL = level_t'(BOOK_DEPTH);

  logic op_clr;
  logic op_add;
  logic op_del;
  logic op_rep;
  logic match_hit;

  logic [BOOK_DEPTH-1:0] match_sel;
  logic [BOOK_DEPTH-1:0] match_above;
  logic [BOOK_DEPTH-1:0] ins_cand;
  logic [BOOK_DEPTH-1:0] ins_above;
  logic [BOOK_DEPTH-1:0] ins_pt;
  logic [BOOK_DEPTH-1:0] shift_right;
  logic [BOOK_DEPTH-1:0] shift_left;
  logic [BOOK_DEPTH-1:0] vol_load;

  // Neighbour values, upper is index+1, lower is index-1
  logic [BOOK_DEPTH-1:0]          vld_upper;
  logic [BOOK_DEPTH-1:0]          vld_lower;
  key_t [BOOK_DEPTH-1:0]          key_upper;
  key_t [BOOK_DEPTH-1:0]          key_lower;
  volume_t [BOOK_DEPTH-1:0]       vol_upper;
  volume_t [BOOK_DEPTH-1:0]       vol_lower;

  // Command decode, nothing happens without a valid pulse
  assign op_clr = i_cmd_vld & (i_cmd == CMD_CLEAR);
  assign op_add = i_cmd_vld & (i_cmd == CMD_ADD);
  assign op_del = i_cmd_vld & (i_cmd == CMD_DELETE);
  assign op_rep = i_cmd_vld & (i_cmd == CMD_REPLACE);

  for (genvar i = 0; i < BOOK_DEPTH; i++) begin : g_scan
    // One-hot match, keys are unique
    assign match_sel[i]   = i_cur_vld[i] & (i_cur_keys[i] == i_cmd_key);
    // Free slot or a level at or below the new key
    assign ins_cand[i]    = ~i_cur_vld[i] | (i_cur_keys[i] <= i_cmd_key);
    // Any candidate or match strictly above this index
    assign ins_above[i]   = |(ins_cand >> (i + 1));
    assign match_above[i] = |(match_sel >> (i + 1));
    // First candidate from the top is the insertion point
    assign ins_pt[i]      = op_add & ins_cand[i] & ~ins_above[i];
  end

  assign match_hit = |match_sel;

  // ADD moves everything below the insertion point one step down
  // Full table with the lowest key: no candidate, entry is dropped
  assign shift_right = {BOOK_DEPTH{op_add}} & ins_above;

  // DELETE pulls entries at and below the match one step up
  assign shift_left  = {BOOK_DEPTH{op_del}} & (match_sel | match_above);

  // Volume written on insert or on a replace hit
  assign vol_load    = ins_pt | ({BOOK_DEPTH{op_rep}} & match_sel);

  for (genvar i = 0; i < BOOK_DEPTH; i++) begin : g_entry
    if (i == BOOK_DEPTH - 1) begin : g_top
      // Top never shifts down, nothing above it
      assign vld_upper[i] = 1'b0;
      assign key_upper[i] = '0;
      assign vol_upper[i] = '0;
    end else begin : g_mid_up
      assign vld_upper[i] = i_cur_vld[i+1];
      assign key_upper[i] = i_cur_keys[i+1];
      assign vol_upper[i] = i_cur_volumes[i+1];
    end

    if (i == 0) begin : g_bottom
      // Bottom empties on a delete shift
      assign vld_lower[i] = 1'b0;
      assign key_lower[i] = '0;
      assign vol_lower[i] = '0;
    end else begin : g_mid_dn
      assign vld_lower[i] = i_cur_vld[i-1];
      assign key_lower[i] = i_cur_keys[i-1];
      assign vol_lower[i] = i_cur_volumes[i-1];
    end

    assign o_nxt_vld[i] = op_clr         ? 1'b0 :
                          ins_pt[i]      ? 1'b1 :
                          shift_right[i] ? vld_upper[i] :
                          shift_left[i]  ? vld_lower[i] :
                          i_cur_vld[i];

    assign o_nxt_keys[i] = ins_pt[i]      ? i_cmd_key :
                           shift_right[i] ? key_upper[i] :
                           shift_left[i]  ? key_lower[i] :
                           i_cur_keys[i];

    assign o_nxt_volumes[i] = vol_load[i]    ? i_cmd_volume :
                              shift_right[i] ? vol_upper[i] :
                              shift_left[i]  ? vol_lower[i] :
                              i_cur_volumes[i];
  end

  // Count saturates at depth, missing delete key leaves it alone
  always_comb begin
    o_nxt_count = i_cur_count;
    if (op_clr) begin
      o_nxt_count = '0;
    end else if (op_add && (i_cur_count < DEPTH_LVL)) begin
      o_nxt_count = i_cur_count + level_t'(1);
    end else if (op_del && match_hit) begin
      o_nxt_count = i_cur_count - level_t'(1);
    end
  end

endmodule

/* logic/book_cmd_port.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic slave command port
// Single cycle ack FSM, command word decode into a
// one-cycle command pulse, top-of-book and count reads
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module book_cmd_port (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_wb_cyc,
  input  logic               i_wb_stb,
  input  logic               i_wb_we,
  input  logic               i_wb_adr,
  input  book_pkg::wb_data_t i_wb_dat,
  output book_pkg::wb_data_t o_wb_dat,
  output logic               o_wb_ack,
  output logic               o_cmd_vld,
  output book_pkg::cmd_t     o_cmd,
  output book_pkg::key_t     o_cmd_key,
  output book_pkg::volume_t  o_cmd_volume,
  input  book_pkg::key_t     i_top_key,
  input  book_pkg::volume_t  i_top_volume,
  input  logic               i_top_vld,
  input  book_pkg::level_t   i_count
);

  import book_pkg::*;

  port_state_t port_state;
  port_state_t port_state_nxt;
  logic        wb_req;
  wb_data_t    rd_word;

  // New transaction only while idle, ack phase ignores the held strobe
  assign wb_req = i_wb_cyc & i_wb_stb & (port_state == PORT_IDLE);

  always_comb begin
    port_state_nxt = port_state;
    case (port_state)
      PORT_IDLE: if (wb_req) port_state_nxt = PORT_ACK;
      PORT_ACK:  port_state_nxt = PORT_IDLE;
      default:   port_state_nxt = PORT_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      port_state <= PORT_IDLE;
      o_cmd_vld  <= 1'b0;
    end else begin
      port_state <= port_state_nxt;
      // One pulse per accepted write
      o_cmd_vld  <= wb_req & i_wb_we;
    end
  end

  // Ack is high for the whole single ack state
  assign o_wb_ack = (port_state == PORT_ACK);

  // Read data mux
  always_comb begin
    rd_word = '0;
    if (i_wb_adr) begin
      rd_word[LEVEL_BITS-1:0] = i_count;
    end else if (i_top_vld) begin
      // Empty table reads as zero key and volume
      rd_word[KEY_LSB +: KEY_BITS]       = i_top_key;
      rd_word[VOLUME_LSB +: VOLUME_BITS] = i_top_volume;
    end
  end

  // Payload captured on the sampling edge
  always_ff @(posedge i_clk) begin
    if (wb_req && i_wb_we) begin
      o_cmd        <= cmd_t'(i_wb_dat[CMD_LSB +: CMD_BITS]);
      o_cmd_key    <= i_wb_dat[KEY_LSB +: KEY_BITS];
      o_cmd_volume <= i_wb_dat[VOLUME_LSB +: VOLUME_BITS];
    end
    if (wb_req && !i_wb_we) begin
      o_wb_dat <= rd_word;
    end
  end

endmodule

/* logic/book_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Order book shared definitions
// Field widths, vector typedefs, command encoding,
// command word field positions and port FSM states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package book_pkg;

  // Default number of price levels held in the table
  localparam int BOOK_DEPTH_DEFAULT = 8;

  // Entry field widths
  localparam int KEY_BITS    = 16;
  localparam int VOLUME_BITS = 14;
  localparam int LEVEL_BITS  = 8;

  // Bus and command widths
  localparam int CMD_BITS     = 2;
  localparam int WB_DATA_BITS = 32;

  typedef logic [KEY_BITS-1:0]     key_t;
  typedef logic [VOLUME_BITS-1:0]  volume_t;
  // Count of valid levels, covers depths up to 255
  typedef logic [LEVEL_BITS-1:0]   level_t;
  typedef logic [WB_DATA_BITS-1:0] wb_data_t;

  // Command field encoding
  typedef enum logic [CMD_BITS-1:0] {
    CMD_CLEAR   = 2'd0,
    CMD_ADD     = 2'd1,
    CMD_DELETE  = 2'd2,
    CMD_REPLACE = 2'd3
  } cmd_t;

  // Command word layout: cmd [31:30], key [29:14], volume [13:0]
  // Read word at adr 0 uses the same key and volume positions
  // Read word at adr 1 carries the count in its low bits
  localparam int CMD_LSB    = 30;
  localparam int KEY_LSB    = 14;
  localparam int VOLUME_LSB = 0;

  // Wishbone slave handshake states
  typedef enum logic {
    PORT_IDLE = 1'b0,
    PORT_ACK  = 1'b1
  } port_state_t;

endpackage
